//--- compile.f
bayer_pkg.sv
line_window.sv
interp_bilinear.sv
rgb_output.sv
demosaic_top.sv
demosaic_assert.sv
tb_demosaic.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the demosaic testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_demosaic \
   -f compile.f -o sim_demosaic > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_demosaic > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log && exit 0 || { echo "simulation ended early"; exit 1; }

//--- tb_demosaic.sv
`timescale 1ns/100ps

module tb_demosaic;

   localparam int timeout_cycles = 300;

   typedef struct packed {
      bayer_pkg::dtype_t dtype;
      logic [23:0]       word;  // rgb for pixels, metadata otherwise
      logic [31:0]       cyc;
   } out_t;

   logic                clk;
   logic                resetb;
   logic                dvi;
   bayer_pkg::token_t   tokeni;
   logic [1:0]          phase;
   logic                dvo;
   bayer_pkg::dtype_t   dtypeo;
   logic [15:0]         meta_datao;
   bayer_pkg::rgb_t     rgb;
   logic [15:0]         frame_pixels;
   logic                frame_done;

   int          cyc = 0;
   int          errors;
   int          passed;
   int          failed;
   int          done_cnt;
   logic [15:0] done_pixels;
   logic [15:0] lfsr;
   logic [9:0]  img [8][8];  // img[row][col]
   out_t        exp_q [$];
   out_t        got_q [$];
   out_t        saved_q [$];

   demosaic_top i_dut (
      .clk          (clk),
      .resetb       (resetb),
      .dvi          (dvi),
      .tokeni       (tokeni),
      .phase        (phase),
      .dvo          (dvo),
      .dtypeo       (dtypeo),
      .meta_datao   (meta_datao),
      .rgb          (rgb),
      .frame_pixels (frame_pixels),
      .frame_done   (frame_done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   function automatic out_t make_out(input bayer_pkg::dtype_t dt, input logic [23:0] w,
                                     input int c);
      out_t o;
      o.dtype  = dt;
      o.word   = w;
      o.cyc    = 32'(c);
      make_out = o;
   endfunction

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (resetb && dvo)
         got_q.push_back(make_out(dtypeo, dtypeo == bayer_pkg::dtype_pixel ?
                                  rgb : {8'h00, meta_datao}, cyc));
      if (resetb && frame_done) begin
         done_cnt++;
         done_pixels = frame_pixels;
      end
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      rand_bits = v;
   endfunction

   function automatic int to8(input int v);
      to8 = (v + 2) / 4 > 255 ? 255 : (v + 2) / 4;
   endfunction

   // Reference colour for the window centred on (y-1, x-1)
   function automatic logic [23:0] expect_rgb(input int y, input int x, input logic [1:0] p);
      int c;
      int plus;
      int diag;
      int hor;
      int ver;
      int r;
      int g;
      int b;
      c    = img[y-1][x-1];
      plus = (img[y-2][x-1] + img[y][x-1] + img[y-1][x-2] + img[y-1][x]) / 4;
      diag = (img[y-2][x-2] + img[y-2][x] + img[y][x-2] + img[y][x]) / 4;
      hor  = (img[y-1][x-2] + img[y-1][x]) / 2;
      ver  = (img[y-2][x-1] + img[y][x-1]) / 2;
      case ({p[1] ^ y[0], p[0] ^ x[0]})
         2'd0: begin
            r = c;
            g = plus;
            b = diag;
         end
         2'd1: begin
            r = hor;
            g = c;
            b = ver;
         end
         2'd2: begin
            r = ver;
            g = c;
            b = hor;
         end
         default: begin
            r = diag;
            g = plus;
            b = c;
         end
      endcase
      expect_rgb = {8'(to8(r)), 8'(to8(g)), 8'(to8(b))};
   endfunction

   task automatic send(input bayer_pkg::dtype_t dt, input logic [15:0] w, input bit keep,
                       input logic [23:0] ew, input bit gaps);
      int idle;
      dvi              = 1'b1;
      tokeni.dtype     = dt;
      tokeni.word.meta = w;
      if (keep)
         exp_q.push_back(make_out(dt, dt == bayer_pkg::dtype_pixel ? ew : {8'h00, w}, cyc + 3));
      @(posedge clk);
      #1;
      dvi = 1'b0;
      if (gaps) begin
         idle = int'(rand_bits(2));
         repeat (idle) begin
            @(posedge clk);
            #1;
         end
      end
   endtask

   task automatic send_frame(input int h, input int w, input logic [1:0] p,
                             input logic [15:0] base, input bit gaps);
      logic [23:0] ew;
      exp_q.delete();
      got_q.delete();
      done_cnt = 0;
      phase    = p;
      send(bayer_pkg::dtype_frame_start, base, 1'b1, '0, gaps);
      for (int y = 0; y < h; y++) begin
         send(bayer_pkg::dtype_row_start, base ^ 16'h1000 ^ 16'(y), y >= 2, '0, gaps);
         for (int x = 0; x < w; x++) begin
            ew = '0;
            if (y >= 2 && x >= 2)
               ew = expect_rgb(y, x, p);
            send(bayer_pkg::dtype_pixel, {6'h00, img[y][x]}, y >= 2 && x >= 2, ew, gaps);
         end
         send(bayer_pkg::dtype_row_end, base ^ 16'h2000 ^ 16'(y), y >= 2, '0, gaps);
      end
      send(bayer_pkg::dtype_frame_end, base ^ 16'hE000, 1'b1, '0, gaps);
   endtask

   task automatic check_frame(input int exp_pixels);
      int t;
      t = 0;
      while (got_q.size() < exp_q.size() && t < timeout_cycles) begin
         @(posedge clk);
         #1;
         t++;
      end
      assert (t < timeout_cycles)
      else begin
         $display("timeout at %0t: only %0d of %0d output tokens arrived", $time,
                  got_q.size(), exp_q.size());
         errors++;
      end
      assert (got_q.size() == exp_q.size())
      else begin
         $display("mismatch at %0t: dvo token count expected %0d got %0d", $time,
                  exp_q.size(), got_q.size());
         errors++;
      end
      foreach (exp_q[i]) begin
         if (i < got_q.size()) begin
            assert (got_q[i].dtype == exp_q[i].dtype && got_q[i].word == exp_q[i].word)
            else begin
               $display("mismatch at %0t: dtypeo/data of token %0d expected %0d/%h got %0d/%h",
                        $time, i, exp_q[i].dtype, exp_q[i].word, got_q[i].dtype, got_q[i].word);
               errors++;
            end
            assert (got_q[i].cyc == exp_q[i].cyc)
            else begin
               $display("mismatch at %0t: dvo cycle of token %0d expected %0d got %0d",
                        $time, i, exp_q[i].cyc, got_q[i].cyc);
               errors++;
            end
         end
      end
      assert (done_cnt == 1)
      else begin
         $display("frame_done pulsed %0d times instead of once", done_cnt);
         errors++;
      end
      assert (done_pixels == 16'(exp_pixels))
      else begin
         $display("mismatch at %0t: frame_pixels expected %0d got %0d", $time,
                  exp_pixels, done_pixels);
         errors++;
      end
   endtask

   task automatic fill_random(input int h, input int w);
      for (int y = 0; y < h; y++)
         for (int x = 0; x < w; x++)
            img[y][x] = rand_bits(10);
   endtask

   task automatic finish_test(input string name, input int err_before);
      if (errors == err_before) begin
         passed++;
         $display("%-24s ok", name);
      end else begin
         failed++;
         $display("%-24s failed with %0d errors", name, errors - err_before);
      end
   endtask

   function automatic int count_type(input bayer_pkg::dtype_t dt);
      count_type = 0;
      foreach (got_q[i])
         if (got_q[i].dtype == dt)
            count_type++;
   endfunction

   task automatic test_border_count();
      int e;
      e = errors;
      fill_random(6, 8);
      send_frame(6, 8, 2'd0, 16'h0100, 1'b0);
      check_frame(24);
      assert (count_type(bayer_pkg::dtype_pixel) == 24 &&
              count_type(bayer_pkg::dtype_row_start) == 4 &&
              count_type(bayer_pkg::dtype_row_end) == 4)
      else begin
         $display("wrong number of pixel, row start or row end tokens after border drop");
         errors++;
      end
      finish_test("border_count", e);
   endtask

   task automatic test_phases();
      int e;
      e = errors;
      for (int p = 0; p < 4; p++) begin
         send_frame(6, 8, 2'(p), 16'h0200 + 16'(p), 1'b0);
         check_frame(24);
      end
      finish_test("phases", e);
   endtask

   task automatic test_flat(input string name, input logic [9:0] v, input logic [23:0] w);
      int e;
      e = errors;
      foreach (img[y, x])
         img[y][x] = v;
      send_frame(5, 7, 2'd1, 16'h0300, 1'b0);
      check_frame(15);
      foreach (got_q[i])
         if (got_q[i].dtype == bayer_pkg::dtype_pixel)
            assert (got_q[i].word == w)
            else begin
               $display("mismatch at %0t: rgb expected %h got %h", $time, w, got_q[i].word);
               errors++;
            end
      finish_test(name, e);
   endtask

   task automatic test_metadata();
      int e;
      e = errors;
      fill_random(4, 6);
      send_frame(4, 6, 2'd3, rand_bits(16), 1'b0);
      check_frame(8);
      finish_test("metadata", e);
   endtask

   task automatic test_gaps();
      int e;
      e = errors;
      fill_random(6, 8);
      send_frame(6, 8, 2'd2, 16'h0500, 1'b0);
      check_frame(24);
      saved_q = got_q;
      send_frame(6, 8, 2'd2, 16'h0500, 1'b1);  // Same frame, idle gaps
      check_frame(24);
      assert (saved_q.size() == got_q.size())
      else begin
         $display("gapped input gave %0d tokens instead of %0d", got_q.size(), saved_q.size());
         errors++;
      end
      foreach (saved_q[i])
         if (i < got_q.size())
            assert ({saved_q[i].dtype, saved_q[i].word} == {got_q[i].dtype, got_q[i].word})
            else begin
               $display("mismatch at %0t: token %0d back-to-back %h gapped %h", $time, i,
                        saved_q[i].word, got_q[i].word);
               errors++;
            end
      finish_test("back_to_back_vs_gaps", e);
   endtask

   task automatic test_latency();
      int e;
      e = errors;
      fill_random(5, 8);
      send_frame(5, 8, 2'd1, 16'h0600, 1'b1);  // Cycle field checked per token
      check_frame(18);
      finish_test("latency", e);
   endtask

   initial begin
      resetb = 1'b0;
      dvi    = 1'b0;
      tokeni = '0;
      phase  = 2'd0;
      errors = 0;
      passed = 0;
      failed = 0;
      lfsr   = 16'd31;
      repeat (2) @(posedge clk);
      #1;
      resetb = 1'b1;
      @(posedge clk);
      #1;
      test_border_count();
      test_phases();
      test_flat("saturation", 10'd1023, 24'hFFFFFF);
      test_flat("rounding", 10'd5, 24'h010101);
      test_metadata();
      test_gaps();
      test_latency();
      $display("tests passed %0d failed %0d, %0d errors", passed, failed, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- demosaic_assert.sv
`timescale 1ns/100ps

module demosaic_assert (
   input logic              clk,
   input logic              resetb,
   input logic              dvi,
   input bayer_pkg::token_t tokeni,
   input logic              dvo,
   input bayer_pkg::dtype_t dtypeo,
   input logic              frame_done
);

   a_quiet_in_reset: assert property (@(posedge clk) !resetb |-> !dvo)
      else $error("dvo high during reset");

   a_done_on_frame_end: assert property (@(posedge clk)
      frame_done |-> dvo && dtypeo == bayer_pkg::dtype_frame_end)
      else $error("frame_done without a frame end on the output");

   // Frame start is never dropped
   a_frame_start_latency: assert property (@(posedge clk) disable iff (!resetb)
      dvi && tokeni.dtype == bayer_pkg::dtype_frame_start
      |-> ##3 dvo && dtypeo == bayer_pkg::dtype_frame_start)
      else $error("frame start did not reach dvo after 3 cycles");

endmodule

bind demosaic_top demosaic_assert i_assert (
   .clk        (clk),
   .resetb     (resetb),
   .dvi        (dvi),
   .tokeni     (tokeni),
   .dvo        (dvo),
   .dtypeo     (dtypeo),
   .frame_done (frame_done)
);

//--- demosaic_top.sv
`timescale 1ns/100ps

module demosaic_top (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             dvi,
   input  bayer_pkg::token_t                tokeni,
   input  logic [1:0]                       phase,
   output logic                             dvo,
   output bayer_pkg::dtype_t                dtypeo,
   output logic [bayer_pkg::data_width-1:0] meta_datao,
   output bayer_pkg::rgb_t                  rgb,
   output logic [15:0]                      frame_pixels,
   output logic                             frame_done
);

   logic                win_dv;
   bayer_pkg::token_t   win_token;
   bayer_pkg::window_t  win;

   logic                mid_dv;
   bayer_pkg::token_t   mid_token;
   bayer_pkg::rgb_raw_t mid_rgb;

   line_window i_line_window (
      .clk       (clk),
      .resetb    (resetb),
      .dvi       (dvi),
      .tokeni    (tokeni),
      .win_dv    (win_dv),
      .win_token (win_token),
      .win       (win)
   );

   interp_bilinear i_interp_bilinear (
      .clk       (clk),
      .resetb    (resetb),
      .phase     (phase),
      .win_dv    (win_dv),
      .win_token (win_token),
      .win       (win),
      .mid_dv    (mid_dv),
      .mid_token (mid_token),
      .mid_rgb   (mid_rgb)
   );

   rgb_output i_rgb_output (
      .clk          (clk),
      .resetb       (resetb),
      .mid_dv       (mid_dv),
      .mid_token    (mid_token),
      .mid_rgb      (mid_rgb),
      .dvo          (dvo),
      .dtypeo       (dtypeo),
      .meta_datao   (meta_datao),
      .rgb          (rgb),
      .frame_pixels (frame_pixels),
      .frame_done   (frame_done)
   );

endmodule

//--- rgb_output.sv
`timescale 1ns/100ps

module rgb_output (
   input  logic                                clk,
   input  logic                                resetb,
   input  logic                                mid_dv,
   input  bayer_pkg::token_t                   mid_token,
   input  bayer_pkg::rgb_raw_t                 mid_rgb,
   output logic                                dvo,
   output bayer_pkg::dtype_t                   dtypeo,
   output logic [bayer_pkg::data_width-1:0]    meta_datao,
   output bayer_pkg::rgb_t                     rgb,
   output logic [15:0]                         frame_pixels,
   output logic                                frame_done
);

   logic [15:0] pix_cnt;

   // Round to nearest, clip at full scale
   function automatic logic [bayer_pkg::out_width-1:0] round_sat(
      input logic [bayer_pkg::pixel_width-1:0] v
   );
      logic [bayer_pkg::pixel_width:0] sum;
      sum = {1'b0, v} + (bayer_pkg::pixel_width + 1)'(2);
      if (sum[bayer_pkg::pixel_width])
         round_sat = '1;
      else
         round_sat = sum[bayer_pkg::pixel_width-1 -: bayer_pkg::out_width];
   endfunction

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo          <= 1'b0;
         dtypeo       <= bayer_pkg::dtype_frame_start;
         meta_datao   <= '0;
         rgb          <= '0;
         pix_cnt      <= '0;
         frame_pixels <= '0;
         frame_done   <= 1'b0;
      end else begin
         dvo        <= mid_dv;
         frame_done <= mid_dv && mid_token.dtype == bayer_pkg::dtype_frame_end;
         if (mid_dv) begin
            dtypeo <= mid_token.dtype;
            if (mid_token.dtype == bayer_pkg::dtype_pixel) begin
               rgb.r   <= round_sat(mid_rgb.r);
               rgb.g   <= round_sat(mid_rgb.g);
               rgb.b   <= round_sat(mid_rgb.b);
               pix_cnt <= pix_cnt + 16'd1;
            end else begin
               meta_datao <= mid_token.word.meta;  // Held over pixels
            end
            if (mid_token.dtype == bayer_pkg::dtype_frame_start)
               pix_cnt <= '0;
            if (mid_token.dtype == bayer_pkg::dtype_frame_end)
               frame_pixels <= pix_cnt;
         end
      end
   end

endmodule

//--- interp_bilinear.sv
`timescale 1ns/100ps

module interp_bilinear (
   input  logic                clk,
   input  logic                resetb,
   input  logic [1:0]          phase,
   input  logic                win_dv,
   input  bayer_pkg::token_t   win_token,
   input  bayer_pkg::window_t  win,
   output logic                mid_dv,
   output bayer_pkg::token_t   mid_token,
   output bayer_pkg::rgb_raw_t mid_rgb
);

   logic row_phase;
   logic col_phase;

   // Sums carry enough bits to avoid overflow before the shift
   logic [bayer_pkg::pixel_width+1:0] plus_sum;
   logic [bayer_pkg::pixel_width+1:0] diamond_sum;
   logic [bayer_pkg::pixel_width:0]   horz_sum;
   logic [bayer_pkg::pixel_width:0]   vert_sum;

   logic [bayer_pkg::pixel_width-1:0] kplus;
   logic [bayer_pkg::pixel_width-1:0] kdiamond;
   logic [bayer_pkg::pixel_width-1:0] khorz;
   logic [bayer_pkg::pixel_width-1:0] kvert;

   assign plus_sum    = win.k01 + win.k21 + win.k10 + win.k12;
   assign diamond_sum = win.k00 + win.k02 + win.k20 + win.k22;
   assign horz_sum    = win.k10 + win.k12;
   assign vert_sum    = win.k01 + win.k21;

   assign kplus    = plus_sum[bayer_pkg::pixel_width+1:2];
   assign kdiamond = diamond_sum[bayer_pkg::pixel_width+1:2];
   assign khorz    = horz_sum[bayer_pkg::pixel_width:1];
   assign kvert    = vert_sum[bayer_pkg::pixel_width:1];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         mid_dv    <= 1'b0;
         mid_token <= '0;
         mid_rgb   <= '0;
         row_phase <= 1'b0;
         col_phase <= 1'b0;
      end else begin
         mid_dv <= win_dv;
         if (win_dv) begin
            mid_token <= win_token;
            case (win_token.dtype)
               bayer_pkg::dtype_frame_start: row_phase <= phase[1];
               bayer_pkg::dtype_row_start:   col_phase <= phase[0];
               bayer_pkg::dtype_row_end:     row_phase <= !row_phase;
               bayer_pkg::dtype_pixel: begin
                  col_phase <= !col_phase;
                  case ({row_phase, col_phase})
                     2'd0: begin  // Red
                        mid_rgb.r <= win.k11;
                        mid_rgb.g <= kplus;
                        mid_rgb.b <= kdiamond;
                     end
                     2'd1: begin  // Green, red row
                        mid_rgb.r <= khorz;
                        mid_rgb.g <= win.k11;
                        mid_rgb.b <= kvert;
                     end
                     2'd2: begin  // Green, blue row
                        mid_rgb.r <= kvert;
                        mid_rgb.g <= win.k11;
                        mid_rgb.b <= khorz;
                     end
                     default: begin  // Blue
                        mid_rgb.r <= kdiamond;
                        mid_rgb.g <= kplus;
                        mid_rgb.b <= win.k11;
                     end
                  endcase
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

//--- line_window.sv
`timescale 1ns/100ps

module line_window (
   input  logic               clk,
   input  logic               resetb,
   input  logic               dvi,
   input  bayer_pkg::token_t  tokeni,
   output logic               win_dv,
   output bayer_pkg::token_t  win_token,
   output bayer_pkg::window_t win
);

   logic [1:0]                         row_cnt;  // Saturates at 2
   logic [bayer_pkg::col_width-1:0]    col_cnt;
   logic [$clog2(bayer_pkg::max_cols)-1:0] addr;
   logic                               is_pix;
   logic                               keep;

   // Two previous rows
   logic [bayer_pkg::pixel_width-1:0] line_a [bayer_pkg::max_cols];  // Row y-1
   logic [bayer_pkg::pixel_width-1:0] line_b [bayer_pkg::max_cols];  // Row y-2

   // Window columns, index 0 is the oldest row
   logic [bayer_pkg::pixel_width-1:0] cur   [3];  // Column x
   logic [bayer_pkg::pixel_width-1:0] col_a [3];  // Column x-1
   logic [bayer_pkg::pixel_width-1:0] col_b [3];  // Column x-2

   assign addr   = col_cnt[$clog2(bayer_pkg::max_cols)-1:0];
   assign is_pix = tokeni.dtype == bayer_pkg::dtype_pixel;

   always_comb begin
      cur[0] = line_b[addr];
      cur[1] = line_a[addr];
      cur[2] = tokeni.word.pix.sample;
   end

   // Border drop
   always_comb begin
      case (tokeni.dtype)
         bayer_pkg::dtype_pixel:
            keep = row_cnt == 2'd2 && col_cnt >= bayer_pkg::col_width'(2);
         bayer_pkg::dtype_row_start,
         bayer_pkg::dtype_row_end:
            keep = row_cnt == 2'd2;
         default:
            keep = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_cnt <= '0;
         col_cnt <= '0;
      end else if (dvi) begin
         case (tokeni.dtype)
            bayer_pkg::dtype_frame_start: begin
               row_cnt <= '0;
               col_cnt <= '0;
            end
            bayer_pkg::dtype_row_start: col_cnt <= '0;
            bayer_pkg::dtype_pixel:     col_cnt <= col_cnt + 1'b1;
            bayer_pkg::dtype_row_end: begin
               if (row_cnt != 2'd2)
                  row_cnt <= row_cnt + 2'd1;
            end
            default: begin
            end
         endcase
      end
   end

   // Line buffers and column shift
   always_ff @(posedge clk) begin
      if (dvi && is_pix) begin
         line_b[addr] <= line_a[addr];
         line_a[addr] <= tokeni.word.pix.sample;
         col_b        <= col_a;
         col_a        <= cur;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         win_dv    <= 1'b0;
         win_token <= '0;
         win       <= '0;
      end else begin
         win_dv <= dvi && keep;
         if (dvi && keep)
            win_token <= tokeni;
         if (dvi && keep && is_pix) begin
            win.k00 <= col_b[0];
            win.k10 <= col_b[1];
            win.k20 <= col_b[2];
            win.k01 <= col_a[0];
            win.k11 <= col_a[1];  // Centre
            win.k21 <= col_a[2];
            win.k02 <= cur[0];
            win.k12 <= cur[1];
            win.k22 <= cur[2];
         end
      end
   end

endmodule

//--- bayer_pkg.sv
package bayer_pkg;

   localparam int pixel_width = 10;   // Raw Bayer sample
   localparam int out_width   = 8;    // Output colour channel
   localparam int data_width  = 16;   // Stream data word
   localparam int max_cols    = 64;   // Longest row held in a line buffer
   localparam int col_width   = 7;    // Counts up to max_cols

   typedef enum logic [2:0] {
      dtype_frame_start = 3'd0,
      dtype_row_start   = 3'd1,
      dtype_pixel       = 3'd2,
      dtype_row_end     = 3'd3,
      dtype_frame_end   = 3'd4
   } dtype_t;

   // Pixel view of a stream word
   typedef struct packed {
      logic [data_width-pixel_width-1:0] rsvd;
      logic [pixel_width-1:0]            sample;
   } pixel_view_t;

   // Pixel tokens carry a sample, frame and row tokens carry metadata
   typedef union packed {
      pixel_view_t           pix;
      logic [data_width-1:0] meta;
   } stream_word_t;

   typedef struct packed {
      dtype_t       dtype;
      stream_word_t word;
   } token_t;

   // kRC with R the row (0 oldest) and C the column (0 leftmost)
   typedef struct packed {
      logic [pixel_width-1:0] k00;
      logic [pixel_width-1:0] k01;
      logic [pixel_width-1:0] k02;
      logic [pixel_width-1:0] k10;
      logic [pixel_width-1:0] k11;
      logic [pixel_width-1:0] k12;
      logic [pixel_width-1:0] k20;
      logic [pixel_width-1:0] k21;
      logic [pixel_width-1:0] k22;
   } window_t;

   typedef struct packed {
      logic [pixel_width-1:0] r;
      logic [pixel_width-1:0] g;
      logic [pixel_width-1:0] b;
   } rgb_raw_t;

   typedef struct packed {
      logic [out_width-1:0] r;
      logic [out_width-1:0] g;
      logic [out_width-1:0] b;
   } rgb_t;

endpackage
